/* verilog/lynx_video_pkg.sv */
package lynx_video_pkg;

  ////////////////////////////////
  // panel and frame buffer
  ////////////////////////////////
  localparam int LCD_W     = 160;
  localparam int LCD_H     = 102;
  localparam int FB_DEPTH  = LCD_W * LCD_H;   // 16320 pixels
  localparam int LAST_ADDR = FB_DEPTH - 1;    // write here closes a frame

  typedef logic [13:0] pixel_addr_t;
  typedef logic [11:0] rgb444_t;              // red in [11:8]
  typedef logic [23:0] rgb888_t;
  typedef logic [1:0]  buf_idx_t;             // 0..2 only

  ////////////////////////////////
  // raster timing
  ////////////////////////////////
  localparam int H_TOTAL  = 445;  // pixel slots per line
  localparam int V_TOTAL  = 270;  // lines per frame
  localparam int HS_START = 350;
  localparam int HS_END   = 382;
  localparam int VS_START = 1;
  localparam int VS_END   = 4;
  localparam int LAND_Y0  = 120;  // first active line, landscape
  localparam int PORT_Y0  = 62;   // first active line, rotated
  localparam int HS_DELAY = 7;    // output hsync lag in pixels

  // screen orientation
  typedef enum logic [1:0] {
    ORIENT_LAND   = 2'd0,
    ORIENT_ROT    = 2'd1,
    ORIENT_ROT180 = 2'd2
  } orient_e;

  // flicker blending over frames
  typedef enum logic [1:0] {
    BLEND_OFF = 2'd0,
    BLEND_2F  = 2'd1,
    BLEND_3F  = 2'd2
  } blend_e;

  // fast-forward button latch
  typedef enum logic [1:0] {
    FF_OFF          = 2'd0,
    FF_HOLD_OFF     = 2'd1,
    FF_LATCHED      = 2'd2,
    FF_HOLD_LATCHED = 2'd3
  } ff_state_e;

endpackage

/* verilog/raster_timing.sv */
`timescale 1ns/1ns

module raster_timing #(
  parameter int PIX_DIV = 9
) (
  input  logic                     clk_sys,
  input  logic                     arst_n,
  input  lynx_video_pkg::orient_e  orient_sel,
  output logic                     pix_ce,
  output logic                     frame_start,
  output logic [8:0]               x,
  output logic [8:0]               y,
  output logic                     hbl,
  output logic                     vbl,
  output logic                     hs_raw,
  output logic                     vs_raw,
  output lynx_video_pkg::orient_e  orient_q
);

  localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;

  logic [DIV_W-1:0] div;
  logic             rotated;

  // pixel enable, one cycle in PIX_DIV
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      div    <= '0;
      pix_ce <= 1'b0;
    end else begin
      div    <= (div == DIV_W'(PIX_DIV - 1)) ? '0 : div + 1'b1;
      pix_ce <= (div == DIV_W'(PIX_DIV - 1));
    end
  end

  assign frame_start = pix_ce && (x == 9'(lynx_video_pkg::H_TOTAL - 1))
                              && (y == 9'(lynx_video_pkg::V_TOTAL - 1));

  ////////////////////////////////
  // beam counters
  ////////////////////////////////
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      x        <= '0;
      y        <= '0;
      orient_q <= lynx_video_pkg::ORIENT_LAND;
    end else if (pix_ce) begin
      if (x == 9'(lynx_video_pkg::H_TOTAL - 1)) begin
        x <= '0;
        y <= frame_start ? '0 : y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
      if (frame_start) orient_q <= orient_sel;  // new frame picks up orientation
    end
  end

  assign rotated = (orient_q != lynx_video_pkg::ORIENT_LAND);

  // active window: 160x102 landscape, 102x160 rotated
  assign hbl = rotated ? (x >= 9'(lynx_video_pkg::LCD_H)) : (x >= 9'(lynx_video_pkg::LCD_W));
  assign vbl = rotated ?
    (y < 9'(lynx_video_pkg::PORT_Y0)) ||
    (y >= 9'(lynx_video_pkg::PORT_Y0 + lynx_video_pkg::LCD_W)) :
    (y < 9'(lynx_video_pkg::LAND_Y0)) ||
    (y >= 9'(lynx_video_pkg::LAND_Y0 + lynx_video_pkg::LCD_H));

  assign hs_raw = (x >= 9'(lynx_video_pkg::HS_START)) && (x < 9'(lynx_video_pkg::HS_END));

  // vsync edges line up with the hsync start column
  assign vs_raw = ((y > 9'(lynx_video_pkg::VS_START)) && (y < 9'(lynx_video_pkg::VS_END))) ||
                  ((y == 9'(lynx_video_pkg::VS_START)) && (x >= 9'(lynx_video_pkg::HS_START))) ||
                  ((y == 9'(lynx_video_pkg::VS_END)) && (x < 9'(lynx_video_pkg::HS_START)));

  a_blank_known : assert property (@(posedge clk_sys) disable iff (!arst_n)
    !$isunknown({hbl, vbl}))
    else $error("raster_timing: blanking unknown");

endmodule

/* verilog/scan_address.sv */
`timescale 1ns/1ns

module scan_address (
  input  logic                         clk_sys,
  input  logic                         arst_n,
  input  logic                         pix_ce,
  input  logic [8:0]                   x,
  input  logic [8:0]                   y,
  input  logic                         hbl,
  input  logic                         vbl,
  input  lynx_video_pkg::orient_e      orient_q,
  output lynx_video_pkg::pixel_addr_t  rd_addr
);

  localparam lynx_video_pkg::pixel_addr_t STRIDE = 14'(lynx_video_pkg::LCD_W);

  // first address of the next display line, given the current line y
  localparam lynx_video_pkg::pixel_addr_t ROT_BASE =
    14'((lynx_video_pkg::LCD_H - 1) * lynx_video_pkg::LCD_W - (lynx_video_pkg::PORT_Y0 - 1));
  localparam lynx_video_pkg::pixel_addr_t ROT180_BASE =
    14'((lynx_video_pkg::LCD_W - 1) + (lynx_video_pkg::PORT_Y0 - 1));

  logic                        line_end;
  lynx_video_pkg::pixel_addr_t y_wide;

  assign line_end = (x == 9'(lynx_video_pkg::H_TOTAL - 1));
  assign y_wide   = 14'(y);

  // rd_addr always holds the address of the pixel now on the beam
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      rd_addr <= '0;
    end else if (pix_ce) begin
      case (orient_q)
        lynx_video_pkg::ORIENT_ROT: begin
          if (!hbl)          rd_addr <= rd_addr - STRIDE;  // up one row
          else if (line_end) rd_addr <= ROT_BASE + y_wide;  // bottom row, next column
        end
        lynx_video_pkg::ORIENT_ROT180: begin
          if (!hbl)          rd_addr <= rd_addr + STRIDE;  // down one row
          else if (line_end) rd_addr <= ROT180_BASE - y_wide;
        end
        default: begin
          if (vbl)       rd_addr <= '0;
          else if (!hbl) rd_addr <= rd_addr + 1'b1;  // rows in order
        end
      endcase
    end
  end

endmodule

/* verilog/frame_store.sv */
`timescale 1ns/1ns

module frame_store (
  input  logic                         clk_sys,
  input  logic                         arst_n,
  input  logic                         pixel_we,
  input  lynx_video_pkg::pixel_addr_t  pixel_addr,
  input  lynx_video_pkg::rgb444_t      pixel_data,
  input  logic                         buffer_en,
  input  logic                         frame_start,
  input  lynx_video_pkg::pixel_addr_t  rd_addr,
  output lynx_video_pkg::rgb444_t      rgb0,
  output lynx_video_pkg::rgb444_t      rgb1,
  output lynx_video_pkg::rgb444_t      rgb2,
  output lynx_video_pkg::buf_idx_t     rd_idx,
  output lynx_video_pkg::buf_idx_t     last_idx
);

  lynx_video_pkg::buf_idx_t wr_idx;
  lynx_video_pkg::buf_idx_t next_idx;
  logic                     frame_done;

  assign frame_done = pixel_we && (pixel_addr == 14'(lynx_video_pkg::LAST_ADDR));

  ////////////////////////////////
  // buffer rotation
  ////////////////////////////////
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      wr_idx   <= '0;
      next_idx <= '0;
      rd_idx   <= '0;
      last_idx <= '0;
    end else begin
      if (!buffer_en) begin
        wr_idx   <= '0;  // single buffer
        next_idx <= '0;
      end else if (frame_done) begin
        next_idx <= wr_idx;  // finished frame goes up next
        wr_idx   <= (wr_idx == 2'd2) ? 2'd0 : wr_idx + 2'd1;
      end
      if (frame_start) begin
        rd_idx   <= next_idx;
        last_idx <= rd_idx;
      end
    end
  end

  // one pixel memory per buffer
  for (genvar b = 0; b < 3; b++) begin : g_bank
    lynx_video_pkg::rgb444_t mem [lynx_video_pkg::FB_DEPTH];
    lynx_video_pkg::rgb444_t rd_q;

    always_ff @(posedge clk_sys) begin
      if (pixel_we && (wr_idx == 2'(b))) mem[pixel_addr] <= pixel_data;
      rd_q <= mem[rd_addr];  // all three read in step for blending
    end
  end

  assign rgb0 = g_bank[0].rd_q;
  assign rgb1 = g_bank[1].rd_q;
  assign rgb2 = g_bank[2].rd_q;

  a_idx_range : assert property (@(posedge clk_sys) disable iff (!arst_n)
    (wr_idx != 2'd3) && (next_idx != 2'd3) && (rd_idx != 2'd3) && (last_idx != 2'd3))
    else $error("frame_store: buffer index out of range");

endmodule

/* verilog/flicker_blend.sv */
`timescale 1ns/1ns

module flicker_blend (
  input  logic                      clk_sys,
  input  logic                      arst_n,
  input  logic                      pix_ce,
  input  lynx_video_pkg::blend_e    blend_sel,
  input  lynx_video_pkg::rgb444_t   rgb0,
  input  lynx_video_pkg::rgb444_t   rgb1,
  input  lynx_video_pkg::rgb444_t   rgb2,
  input  lynx_video_pkg::buf_idx_t  rd_idx,
  input  lynx_video_pkg::buf_idx_t  last_idx,
  output lynx_video_pkg::rgb888_t   blend_rgb
);

  lynx_video_pkg::rgb444_t rgb_now;
  lynx_video_pkg::rgb444_t rgb_last;
  lynx_video_pkg::rgb888_t mixed;

  // one 4-bit channel to 8 bits
  function automatic logic [7:0] mix_chan(input lynx_video_pkg::blend_e mode,
                                          input logic [3:0] now_n,
                                          input logic [3:0] last_n,
                                          input logic [3:0] c0,
                                          input logic [3:0] c1,
                                          input logic [3:0] c2);
    logic [4:0]  sum2;
    logic [5:0]  sum3;
    logic [23:0] prod;
    sum2 = 5'(now_n) + 5'(last_n);
    sum3 = 6'(c0) + 6'(c1) + 6'(c2);
    prod = 24'({sum3, sum3[5:4]}) * 24'd21845;  // times 4/3, scaled by 2^14
    case (mode)
      lynx_video_pkg::BLEND_OFF: mix_chan = {now_n, now_n};
      lynx_video_pkg::BLEND_2F:  mix_chan = {sum2, sum2[4:2]};
      default:                   mix_chan = prod[21:14];
    endcase
  endfunction

  assign rgb_now  = (rd_idx == 2'd0) ? rgb0 : (rd_idx == 2'd1) ? rgb1 : rgb2;
  assign rgb_last = (last_idx == 2'd0) ? rgb0 : (last_idx == 2'd1) ? rgb1 : rgb2;

  always_comb begin
    for (int ch = 0; ch < 3; ch++) begin
      mixed[ch*8 +: 8] = mix_chan(blend_sel, rgb_now[ch*4 +: 4], rgb_last[ch*4 +: 4],
                                  rgb0[ch*4 +: 4], rgb1[ch*4 +: 4], rgb2[ch*4 +: 4]);
    end
  end

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) blend_rgb <= '0;
    else if (pix_ce) blend_rgb <= mixed;  // one pixel behind the beam
  end

endmodule

/* verilog/video_sync_out.sv */
`timescale 1ns/1ns

module video_sync_out (
  input  logic                     clk_sys,
  input  logic                     arst_n,
  input  logic                     pix_ce,
  input  logic                     hbl,
  input  logic                     vbl,
  input  logic                     hs_raw,
  input  logic                     vs_raw,
  input  lynx_video_pkg::rgb888_t  blend_rgb,
  output lynx_video_pkg::rgb888_t  video_rgb,
  output logic                     video_de,
  output logic                     video_hs,
  output logic                     video_vs
);

  localparam int CNT_W = $clog2(lynx_video_pkg::HS_DELAY + 1);

  logic             de_d1;  // matches the blend stage latency
  logic             hs_prev;
  logic             vs_prev;
  logic [CNT_W-1:0] hs_cnt;

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      de_d1     <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      hs_cnt    <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
    end else if (pix_ce) begin
      de_d1     <= !(hbl || vbl);
      video_de  <= de_d1;
      video_rgb <= de_d1 ? blend_rgb : '0;  // black outside the window
      hs_prev   <= hs_raw;
      vs_prev   <= vs_raw;
      if (hs_raw && !hs_prev) hs_cnt <= CNT_W'(lynx_video_pkg::HS_DELAY);
      else if (hs_cnt != '0)  hs_cnt <= hs_cnt - 1'b1;
      video_hs  <= (hs_cnt == CNT_W'(1));  // keeps clear of the vsync pulse
      video_vs  <= vs_raw && !vs_prev;
    end
  end

  a_hs_vs_apart : assert property (@(posedge clk_sys) disable iff (!arst_n)
    !(video_hs && video_vs))
    else $error("video_sync_out: hsync and vsync overlap");

endmodule

/* verilog/ff_latch_ctrl.sv */
`timescale 1ns/1ns

module ff_latch_ctrl #(
  parameter int FF_TAP_CYCLES = 12_800_000
) (
  input  logic clk_sys,
  input  logic arst_n,
  input  logic ff_btn,
  output logic fast_forward
);

  localparam int                 CNT_W   = $clog2(FF_TAP_CYCLES + 1);
  localparam logic [CNT_W-1:0]   TAP_MAX = CNT_W'(FF_TAP_CYCLES);

  lynx_video_pkg::ff_state_e state;
  lynx_video_pkg::ff_state_e state_nx;
  logic [CNT_W-1:0]          hold_cnt;

  always_comb begin
    state_nx = state;
    case (state)
      lynx_video_pkg::FF_OFF:      if (ff_btn) state_nx = lynx_video_pkg::FF_HOLD_OFF;
      lynx_video_pkg::FF_HOLD_OFF: begin
        if (!ff_btn) begin
          // short tap latches, long hold was momentary
          state_nx = (hold_cnt < TAP_MAX) ? lynx_video_pkg::FF_LATCHED
                                          : lynx_video_pkg::FF_OFF;
        end
      end
      lynx_video_pkg::FF_LATCHED:  if (ff_btn) state_nx = lynx_video_pkg::FF_HOLD_LATCHED;
      default:                     if (!ff_btn) state_nx = lynx_video_pkg::FF_OFF;
    endcase
  end

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      state        <= lynx_video_pkg::FF_OFF;
      hold_cnt     <= '0;
      fast_forward <= 1'b0;
    end else begin
      state        <= state_nx;
      fast_forward <= (state_nx != lynx_video_pkg::FF_OFF);
      if (state != lynx_video_pkg::FF_HOLD_OFF) hold_cnt <= '0;
      else if (hold_cnt != TAP_MAX)             hold_cnt <= hold_cnt + 1'b1;  // saturates
    end
  end

  a_state_legal : assert property (@(posedge clk_sys) disable iff (!arst_n)
    state inside {lynx_video_pkg::FF_OFF, lynx_video_pkg::FF_HOLD_OFF,
                  lynx_video_pkg::FF_LATCHED, lynx_video_pkg::FF_HOLD_LATCHED})
    else $error("ff_latch_ctrl: illegal state");

endmodule

/* verilog/lynx_video_top.sv */
`timescale 1ns/1ns

module lynx_video_top #(
  parameter int PIX_DIV       = 9,
  parameter int FF_TAP_CYCLES = 12_800_000
) (
  input  logic                         clk_sys,
  input  logic                         arst_n,
  input  logic                         pixel_we,
  input  lynx_video_pkg::pixel_addr_t  pixel_addr,
  input  lynx_video_pkg::rgb444_t      pixel_data,
  input  lynx_video_pkg::orient_e      orient_sel,
  input  lynx_video_pkg::blend_e       blend_sel,
  input  logic                         buffer_en,
  input  logic                         ff_btn,
  output lynx_video_pkg::rgb888_t      video_rgb,
  output logic                         video_de,
  output logic                         video_hs,
  output logic                         video_vs,
  output logic                         pix_ce,
  output logic                         fast_forward
);

  logic                         frame_start;
  logic [8:0]                   x;
  logic [8:0]                   y;
  logic                         hbl;
  logic                         vbl;
  logic                         hs_raw;
  logic                         vs_raw;
  lynx_video_pkg::orient_e      orient_q;
  lynx_video_pkg::pixel_addr_t  rd_addr;
  lynx_video_pkg::rgb444_t      rgb0;
  lynx_video_pkg::rgb444_t      rgb1;
  lynx_video_pkg::rgb444_t      rgb2;
  lynx_video_pkg::buf_idx_t     rd_idx;
  lynx_video_pkg::buf_idx_t     last_idx;
  lynx_video_pkg::rgb888_t      blend_rgb;

  ////////////////////////////////
  // video path
  ////////////////////////////////
  raster_timing #(.PIX_DIV(PIX_DIV)) u_timing (
    .clk_sys, .arst_n, .orient_sel, .pix_ce, .frame_start,
    .x, .y, .hbl, .vbl, .hs_raw, .vs_raw, .orient_q
  );

  scan_address u_scan (
    .clk_sys, .arst_n, .pix_ce, .x, .y, .hbl, .vbl, .orient_q, .rd_addr
  );

  frame_store u_store (
    .clk_sys, .arst_n, .pixel_we, .pixel_addr, .pixel_data, .buffer_en,
    .frame_start, .rd_addr, .rgb0, .rgb1, .rgb2, .rd_idx, .last_idx
  );

  flicker_blend u_blend (
    .clk_sys, .arst_n, .pix_ce, .blend_sel, .rgb0, .rgb1, .rgb2,
    .rd_idx, .last_idx, .blend_rgb
  );

  video_sync_out u_out (
    .clk_sys, .arst_n, .pix_ce, .hbl, .vbl, .hs_raw, .vs_raw, .blend_rgb,
    .video_rgb, .video_de, .video_hs, .video_vs
  );

  // fast-forward button
  ff_latch_ctrl #(.FF_TAP_CYCLES(FF_TAP_CYCLES)) u_ff (
    .clk_sys, .arst_n, .ff_btn, .fast_forward
  );

endmodule

/* bench/tb_video_model.svh */
// three frame buffers as the bench wrote them
lynx_video_pkg::rgb444_t buf_mem [3][lynx_video_pkg::FB_DEPTH];
int                      wr_buf      = 0;
int                      next_buf    = 0;
int                      show_buf    = 0;
int                      prev_buf    = 0;
logic                    buf_on      = 1'b0;
lynx_video_pkg::orient_e orient_pend = lynx_video_pkg::ORIENT_LAND;
lynx_video_pkg::orient_e orient_now  = lynx_video_pkg::ORIENT_LAND;
lynx_video_pkg::blend_e  blend_now   = lynx_video_pkg::BLEND_OFF;

// one write, the last address hands the buffer over
function automatic void store_pixel(input int addr, input lynx_video_pkg::rgb444_t data);
  buf_mem[wr_buf][addr] = data;
  if (buf_on && (addr == lynx_video_pkg::LAST_ADDR)) begin
    next_buf = wr_buf;
    wr_buf   = (wr_buf + 1) % 3;
  end
endfunction

function automatic void advance_frame();
  prev_buf   = show_buf;
  show_buf   = next_buf;
  orient_now = orient_pend;  // latched at the top of the frame
endfunction

// buffer address of the nth visible pixel of a frame
function automatic int display_addr(input int n);
  int row;
  int col;
  row = n / lynx_video_pkg::LCD_H;
  col = n % lynx_video_pkg::LCD_H;
  case (orient_now)
    lynx_video_pkg::ORIENT_ROT:    return (lynx_video_pkg::LCD_H - 1 - col) * 160 + row;
    lynx_video_pkg::ORIENT_ROT180: return col * 160 + (lynx_video_pkg::LCD_W - 1 - row);
    default:                       return n;
  endcase
endfunction

function automatic logic [7:0] mix_nibble(input int cur, input int prev, input int sum3);
  int s;
  case (blend_now)
    lynx_video_pkg::BLEND_2F: s = ((cur + prev) << 3) | ((cur + prev) >> 2);
    lynx_video_pkg::BLEND_3F: s = (((sum3 << 2) | (sum3 >> 4)) * 21845) >> 14;
    default:                  s = cur * 17;  // nibble twice
  endcase
  return 8'(s);
endfunction

function automatic lynx_video_pkg::rgb888_t expect_pixel(input int n);
  int                      a;
  int                      sum3;
  lynx_video_pkg::rgb888_t res;
  a = display_addr(n);
  for (int ch = 0; ch < 3; ch++) begin
    sum3 = int'(buf_mem[0][a][ch*4 +: 4]) + int'(buf_mem[1][a][ch*4 +: 4]) +
           int'(buf_mem[2][a][ch*4 +: 4]);
    res[ch*8 +: 8] = mix_nibble(int'(buf_mem[show_buf][a][ch*4 +: 4]),
                                int'(buf_mem[prev_buf][a][ch*4 +: 4]), sum3);
  end
  return res;
endfunction

/* bench/tb_lynx_video.sv */
`timescale 1ns/1ns

module tb_lynx_video;

  localparam int PIX_DIV        = 2;
  localparam int FF_TAP_CYCLES  = 64;
  localparam int FRAMES         = 8;
  localparam int TIMEOUT_CYCLES = (FRAMES + 1) * lynx_video_pkg::H_TOTAL *
                                  lynx_video_pkg::V_TOTAL * PIX_DIV * 6 / 5;

  logic                        clk_sys = 1'b0;
  logic                        arst_n;
  logic                        pixel_we;
  lynx_video_pkg::pixel_addr_t pixel_addr;
  lynx_video_pkg::rgb444_t     pixel_data;
  lynx_video_pkg::orient_e     orient_sel;
  lynx_video_pkg::blend_e      blend_sel;
  logic                        buffer_en;
  logic                        ff_btn;
  lynx_video_pkg::rgb888_t     video_rgb;
  logic                        video_de;
  logic                        video_hs;
  logic                        video_vs;
  logic                        pix_ce;
  logic                        fast_forward;

  int                          errors    = 0;
  int                          pix_count = 0;
  int                          hs_count  = 0;
  int                          vs_count  = 0;
  int                          ce_gap    = 0;  // cycles since the last pixel enable
  lynx_video_pkg::ff_state_e   ff_state  = lynx_video_pkg::FF_OFF;
  int                          ff_hold   = 0;
  logic                        ff_expect = 1'b0;

  `include "tb_video_model.svh"

  lynx_video_top #(.PIX_DIV(PIX_DIV), .FF_TAP_CYCLES(FF_TAP_CYCLES)) u_dut (.*);

  always #4 clk_sys = ~clk_sys;

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic check_rgb(input lynx_video_pkg::rgb888_t got,
                           input lynx_video_pkg::rgb888_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t ns: %s, got %06h expected %06h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "colour mismatch");
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      errors++;
      $display("FAILED %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_ff(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t ns: %s, got %b expected %b", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "fast_forward mismatch");
    end
  endtask

  // pixel enable spacing, pulse counts, blanking and pixel colours
  always @(posedge clk_sys) begin
    if (arst_n) begin
      if (!video_de) check_rgb(video_rgb, '0, "colour while blanked");
      if (pix_ce) begin
        if (ce_gap != 0) check_count(ce_gap, PIX_DIV, "clock cycles per pixel enable");
        ce_gap = 1;
        if (video_vs) begin
          if (vs_count > 0) begin  // first interval after reset is partial
            check_count(hs_count, lynx_video_pkg::V_TOTAL, "hsync pulses per frame");
            check_count(pix_count, lynx_video_pkg::FB_DEPTH, "active pixels per frame");
          end
          vs_count++;
          hs_count  = 0;
          pix_count = 0;
        end
        if (video_hs) hs_count++;
        if (video_de) begin
          if (vs_count > 0) check_rgb(video_rgb, expect_pixel(pix_count), "pixel colour");
          pix_count++;
        end
      end else if (ce_gap != 0) begin
        ce_gap++;
      end
    end
  end

  // fast-forward model, output one cycle behind the button
  always @(posedge clk_sys) begin
    if (arst_n) begin
      check_ff(fast_forward, ff_expect, "fast_forward against model");
      case (ff_state)
        lynx_video_pkg::FF_OFF: begin
          if (ff_btn) ff_state = lynx_video_pkg::FF_HOLD_OFF;
          ff_hold = 0;
        end
        lynx_video_pkg::FF_HOLD_OFF: begin
          if (!ff_btn) ff_state = (ff_hold < FF_TAP_CYCLES) ? lynx_video_pkg::FF_LATCHED
                                                            : lynx_video_pkg::FF_OFF;
          ff_hold++;
        end
        lynx_video_pkg::FF_LATCHED: if (ff_btn) ff_state = lynx_video_pkg::FF_HOLD_LATCHED;
        default:                    if (!ff_btn) ff_state = lynx_video_pkg::FF_OFF;
      endcase
      ff_expect = (ff_state != lynx_video_pkg::FF_OFF);
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic wait_vsync();
    @(posedge clk_sys);
    while (!(pix_ce && video_vs)) @(posedge clk_sys);
  endtask

  task automatic apply_settings(input lynx_video_pkg::orient_e o,
                                input lynx_video_pkg::blend_e b, input logic en);
    orient_sel <= o;
    blend_sel  <= b;
    buffer_en  <= en;
    orient_pend = o;
    blend_now   = b;  // blend select acts at once
    buf_on      = en;
    if (!en) begin
      wr_buf   = 0;
      next_buf = 0;
    end
  endtask

  task automatic write_frame();
    lynx_video_pkg::rgb444_t d;
    for (int a = 0; a < lynx_video_pkg::FB_DEPTH; a++) begin
      @(posedge clk_sys);
      d = 12'($urandom);
      pixel_we   <= 1'b1;
      pixel_addr <= 14'(a);
      pixel_data <= d;
      store_pixel(a, d);
    end
    @(posedge clk_sys);
    pixel_we <= 1'b0;
  endtask

  task automatic run_video();
    lynx_video_pkg::orient_e orient_seq [FRAMES] = '{
      lynx_video_pkg::ORIENT_LAND, lynx_video_pkg::ORIENT_LAND, lynx_video_pkg::ORIENT_ROT,
      lynx_video_pkg::ORIENT_ROT180, lynx_video_pkg::ORIENT_LAND, lynx_video_pkg::ORIENT_LAND,
      lynx_video_pkg::ORIENT_ROT, lynx_video_pkg::ORIENT_LAND};
    lynx_video_pkg::blend_e  blend_seq [FRAMES] = '{
      lynx_video_pkg::BLEND_OFF, lynx_video_pkg::BLEND_OFF, lynx_video_pkg::BLEND_OFF,
      lynx_video_pkg::BLEND_2F, lynx_video_pkg::BLEND_3F, lynx_video_pkg::BLEND_3F,
      lynx_video_pkg::BLEND_OFF, lynx_video_pkg::BLEND_2F};
    logic                    buf_seq [FRAMES] = '{1, 1, 1, 1, 1, 0, 0, 0};
    for (int f = 0; f < FRAMES; f++) begin
      wait_vsync();
      advance_frame();
      apply_settings(orient_seq[f], blend_seq[f], buf_seq[f]);
      write_frame();  // done long before the first active line
    end
    wait_vsync();
  endtask

  task automatic press_button(input int len);
    @(posedge clk_sys);
    ff_btn <= 1'b1;
    repeat (len) @(posedge clk_sys);
    check_ff(fast_forward, 1'b1, "fast_forward low while button held");
    ff_btn <= 1'b0;
    repeat (8) @(posedge clk_sys);
  endtask

  task automatic run_ff();
    repeat (16) @(posedge clk_sys);
    press_button(10);  // short tap
    check_ff(fast_forward, 1'b1, "short tap did not latch fast_forward");
    press_button(12);
    check_ff(fast_forward, 1'b0, "second tap did not release fast_forward");
    press_button(4 * FF_TAP_CYCLES);  // long hold
    check_ff(fast_forward, 1'b0, "long hold left fast_forward on");
  endtask

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_sys);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(32'h42c6b0a0));
    arst_n     <= 1'b0;
    pixel_we   <= 1'b0;
    pixel_addr <= '0;
    pixel_data <= '0;
    orient_sel <= lynx_video_pkg::ORIENT_LAND;
    blend_sel  <= lynx_video_pkg::BLEND_OFF;
    buffer_en  <= 1'b0;
    ff_btn     <= 1'b0;
    repeat (8) @(posedge clk_sys);
    arst_n <= 1'b1;
    fork
      run_video();
      run_ff();
    join
    repeat (4) @(posedge clk_sys);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+bench
verilog/lynx_video_pkg.sv
verilog/raster_timing.sv
verilog/scan_address.sv
verilog/frame_store.sv
verilog/flicker_blend.sv
verilog/video_sync_out.sv
verilog/ff_latch_ctrl.sv
verilog/lynx_video_top.sv
bench/tb_lynx_video.sv

/* run_sim.sh */
#!/bin/sh
# build and run the video testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_lynx_video \
  -f files.f -o tb_lynx_video
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_lynx_video > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation passed"
exit 0
